// File: tests/gb_support_cases.txt
# Columns: opcode, then hex operands a..f. KIND idx kind core_reset, PAL word, CAPS caps
# OPTS mode rom_gb2 dupe autosave, BSTART idx, BWORD data, BFILL count data, BEND sum caps
# MODE sys idx game1 game2 is_gbc megaduck, MOUNT present, XFER start rd last, CRAMW/PEND pending
CAPS 6
OPTS 1 0 0 0
BSTART 05
BWORD 1111
BEND 0 2
OPTS 2 0 0 0
BSTART 04
BFILL 168 ffff
BWORD 00e0
BEND 2ce10 6
BSTART 04
BFILL 17b ffff
BWORD 00e0
BEND 2f3ea 3
BSTART 04
BWORD 1234
BEND 46 0
KIND 01 20 1
KIND c1 20 1
KIND 80 20 1
KIND 81 30 1
KIND 03 08 0
KIND 04 04 1
KIND 05 02 1
KIND 06 01 1
KIND 02 00 0
PAL 1234
PAL abcd
PAL 00ff
MODE 1 01 0 0 0 0
MODE 2 01 0 0 1 0
MODE 3 01 0 0 0 1
MODE 0 01 1 1 1 0
MODE 0 41 1 1 0 0
MODE 0 80 0 1 1 0
MODE 0 80 0 0 0 0
MODE 0 81 0 0 0 1
MODE 1 81 0 0 0 0
MODE 2 81 0 0 1 0
OPTS 0 0 0 1
MOUNT 0
PEND 0
XFER 1 1 1ff
XFER 2 0 1ff
OPTS 0 1 1 1
XFER 1 1 0ff
OPTS 0 0 1 1
MOUNT 1
XFER 0 1 0ff
CRAMW 1
XFER 3 0 0ff
PEND 0

// File: files.f
+incdir+rtl
rtl/gb_support_pkg.sv
rtl/download_classifier.sv
rtl/boot_rom_monitor.sv
rtl/palette_store.sv
rtl/backup_ram_sequencer.sv
rtl/gb_support_top.sv
tests/tb_gb_support.sv

// File: Bender.yml
package:
  name: gb_support

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gb_support_pkg.sv
      - rtl/download_classifier.sv
      - rtl/boot_rom_monitor.sv
      - rtl/palette_store.sv
      - rtl/backup_ram_sequencer.sv
      - rtl/gb_support_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_gb_support.sv

// File: tests/tb_gb_support.sv
/*
 * Self-checking testbench for gb_support_top, acting as host, SD card and both cores.
 * Scenarios come from tests/gb_support_cases.txt, so run from the project root.
 * SD acknowledge delays come from a fixed-seed Galois LFSR.
 * The first error stops the run.
 */
`include "gb_support_macros.svh"

module tb_gb_support;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT    = 200;
	localparam int W_REQ      = 0;
	localparam int W_REQ_DROP = 1;
	localparam int W_IDLE     = 2;
	localparam int W_RELEASE  = 3;

	logic                              clk_sys;
	logic                              reset;
	gb_support_pkg::dl_bus_t           dl;
	gb_support_pkg::user_opts_t        opts;
	logic                              osd_open;
	gb_support_pkg::sd_host_t          sd;
	logic                              cram_wr1;
	logic                              cram_wr2;
	logic                              has_save1;
	logic                              has_save2;
	logic [`GB_DL_DATA_W-1:0]          bk_q1;
	logic [`GB_DL_DATA_W-1:0]          bk_q2;
	logic                              is_gbc_game1;
	logic                              is_gbc_game2;
	gb_support_pkg::dl_kind_t          kind;
	logic                              dl_start;
	logic                              dl_end;
	logic                              rom_bank_gb2;
	logic                              core_reset;
	logic                              is_gbc;
	logic                              megaduck;
	gb_support_pkg::boot_caps_t        caps;
	logic [`GB_CHECKSUM_W-1:0]         checksum;
	gb_support_pkg::palette_t          palette;
	logic                              tint_loaded;
	gb_support_pkg::sd_req_t           req;
	logic [`GB_DL_DATA_W-1:0]          sd_buff_din;
	logic [`GB_BK_ADDR_W-1:0]          bk_addr;
	logic [`GB_DL_DATA_W-1:0]          bk_data;
	logic                              bk_wr1;
	logic                              bk_wr2;
	logic                              bk_busy;
	logic                              bk_loading;
	logic                              sav_pending;
	logic                              sav_supported;
	logic                              led_busy;

	logic [31:0]              lfsr_state;
	logic [`GB_PALETTE_W-1:0] pal_model;
	int                       cases_run;

	gb_support_top i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Checking and waiting
	////////////////////////////////////////////////////////////
	task automatic abort_run();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic cond_met(input int cond);
		case (cond)
			W_REQ:      return req.rd | req.wr;
			W_REQ_DROP: return !(req.rd | req.wr);
			W_IDLE:     return !bk_busy;
			default:    return !core_reset;
		endcase
	endfunction

	// Polls on falling edges, where outputs are settled
	task automatic wait_until(input int cond, input string what);
		int n;
		n = 0;
		while (!cond_met(cond)) begin
			@(negedge clk_sys);
			n++;
			if (n > TIMEOUT) begin
				$display("ERROR: timed out waiting for %s", what);
				abort_run();
			end
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic random_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host download side
	////////////////////////////////////////////////////////////
	task automatic start_download(input logic [7:0] idx);
		@(posedge clk_sys);
		dl.active     <= 1'b1;
		dl.wr         <= 1'b0;
		dl.addr       <= '0;
		dl.index.code <= idx;
	endtask

	task automatic write_word(input logic [15:0] data);
		@(posedge clk_sys);
		dl.wr   <= 1'b1;
		dl.data <= data;
		dl.addr <= dl.addr + 1'b1;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		dl.active <= 1'b0;
		dl.wr     <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// SD host model
	////////////////////////////////////////////////////////////
	task automatic serve_sector(input logic [8:0] s, input logic rd);
		int   delay;
		logic exp_wr1;
		logic exp_wr2;
		wait_until(W_REQ, "an SD request");
		check("req.lba", req.lba, s);
		check("req.rd", req.rd, rd);
		check("req.wr", req.wr, !rd);
		// Cores stay held for the whole load
		if (rd)
			check("core_reset", core_reset, 1'b1);
		random_bits(2, delay);
		repeat (delay) @(posedge clk_sys);
		@(posedge clk_sys);
		sd.ack <= 1'b1;
		@(negedge clk_sys);
		wait_until(W_REQ_DROP, "the SD request to drop");
		@(posedge clk_sys);
		sd.buff_wr   <= rd;
		sd.buff_addr <= s[7:0] ^ 8'h3c;
		sd.buff_dout <= {7'h2a, s};
		@(negedge clk_sys);
		exp_wr1 = rd && !s[8] && !(opts.rom_load_gb2 && opts.dupe_save_gb2);
		exp_wr2 = rd && (s[8] || opts.dupe_save_gb2);
		check("bk_wr1", bk_wr1, exp_wr1);
		check("bk_wr2", bk_wr2, exp_wr2);
		check("bk_addr", bk_addr, {1'b0, s[7:0], sd.buff_addr});
		check("bk_data", bk_data, sd.buff_dout);
		check("sd_buff_din", sd_buff_din, s[8] ? bk_q2 : bk_q1);
		@(posedge clk_sys);
		sd.buff_wr <= 1'b0;
		sd.ack     <= 1'b0;
		@(negedge clk_sys);
	endtask

	// start: 0 already running, 1 load request, 2 save request, 3 menu open
	task automatic run_transfer(input int start, input logic rd, input logic [8:0] last);
		@(posedge clk_sys);
		case (start)
			1: opts.load_req <= 1'b1;
			2: opts.save_req <= 1'b1;
			3: osd_open <= 1'b1;
			default: ;
		endcase
		@(posedge clk_sys);
		opts.load_req <= 1'b0;
		opts.save_req <= 1'b0;
		@(negedge clk_sys);
		for (int i = 0; i <= last; i++)
			serve_sector(9'(i), rd);
		wait_until(W_IDLE, "the end of the transfer");
		check("bk_loading", bk_loading, 1'b0);
		check("req.rd", req.rd, 1'b0);
		check("req.wr", req.wr, 1'b0);
		@(posedge clk_sys);
		osd_open <= 1'b0;
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// Scenarios
	////////////////////////////////////////////////////////////
	task automatic run_case(input string op, input logic [31:0] arg [6]);
		case (op)
			"KIND": begin
				start_download(arg[0][7:0]);
				@(negedge clk_sys);
				check("kind", kind, arg[1]);
				check("core_reset", core_reset, arg[2][0]);
				end_download();
			end
			"PAL": begin
				start_download(`GB_DL_PALETTE);
				write_word(arg[0][15:0]);
				end_download();
				pal_model = {pal_model[`GB_PALETTE_W-17:0], arg[0][7:0], arg[0][15:8]};
				check("palette", palette, pal_model[`GB_PALETTE_W-1:32]);
				check("tint_loaded", tint_loaded, 1'b1);
			end
			"OPTS": begin
				@(posedge clk_sys);
				opts.sys_mode      <= gb_support_pkg::sys_mode_e'(arg[0][1:0]);
				opts.rom_load_gb2  <= arg[1][0];
				opts.dupe_save_gb2 <= arg[2][0];
				opts.autosave      <= arg[3][0];
				@(negedge clk_sys);
			end
			"CAPS": begin
				@(negedge clk_sys);
				check("caps", caps, arg[0]);
			end
			"BSTART": start_download(arg[0][7:0]);
			"BWORD":  write_word(arg[0][15:0]);
			"BFILL": begin
				repeat (arg[0]) write_word(arg[1][15:0]);
			end
			"BEND": begin
				end_download();
				check("checksum", checksum, arg[0]);
				check("caps", caps, arg[1]);
			end
			"MODE": begin
				@(posedge clk_sys);
				opts.sys_mode     <= gb_support_pkg::sys_mode_e'(arg[0][1:0]);
				// Bank option flips every time so the latch has to follow it
				opts.rom_load_gb2 <= ~opts.rom_load_gb2;
				is_gbc_game1      <= arg[2][0];
				is_gbc_game2      <= arg[3][0];
				start_download(arg[1][7:0]);
				@(posedge clk_sys);
				@(negedge clk_sys);
				check("dl_start", dl_start, 1'b1);
				check("rom_bank_gb2", rom_bank_gb2, opts.rom_load_gb2);
				@(negedge clk_sys);
				check("dl_start", dl_start, 1'b0);
				end_download();
				check("dl_end", dl_end, 1'b1);
				wait_until(W_RELEASE, "core reset release");
				check("is_gbc", is_gbc, arg[4][0]);
				check("megaduck", megaduck, arg[5][0]);
			end
			"MOUNT": begin
				@(posedge clk_sys);
				sd.img_present <= arg[0][0];
				start_download(8'h01);
				repeat (2) @(posedge clk_sys);
				sd.img_mounted <= 1'b1;
				@(posedge clk_sys);
				sd.img_mounted <= 1'b0;
				end_download();
				check("sav_supported", sav_supported, 1'b1);
			end
			"XFER": run_transfer(arg[0], arg[1][0], arg[2][8:0]);
			"CRAMW": begin
				@(posedge clk_sys);
				cram_wr1 <= 1'b1;
				@(posedge clk_sys);
				cram_wr1 <= 1'b0;
				@(negedge clk_sys);
				check("sav_pending", sav_pending, arg[0][0]);
				check("led_busy", led_busy, arg[0][0]);
			end
			"PEND": begin
				@(negedge clk_sys);
				check("sav_pending", sav_pending, arg[0][0]);
				check("led_busy", led_busy, arg[0][0]);
			end
			default: begin
				$display("ERROR: unknown opcode %s in the cases file", op);
				abort_run();
			end
		endcase
	endtask

	task automatic run_cases();
		int          fd;
		int          n;
		string       line;
		string       op;
		logic [31:0] arg [6];
		fd = $fopen("tests/gb_support_cases.txt", "r");
		if (fd == 0) begin
			$display("ERROR: the cases file could not be opened");
			abort_run();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
				foreach (arg[i])
					arg[i] = '0;
				n = $sscanf(line, "%s %h %h %h %h %h %h",
				            op, arg[0], arg[1], arg[2], arg[3], arg[4], arg[5]);
				run_case(op, arg);
				cases_run++;
			end
		end
		$fclose(fd);
	endtask

	initial begin
		reset        = 1'b1;
		dl           = '0;
		opts         = '0;
		osd_open     = 1'b0;
		sd           = '0;
		cram_wr1     = 1'b0;
		cram_wr2     = 1'b0;
		has_save1    = 1'b1;
		has_save2    = 1'b0;
		bk_q1        = 16'ha5c1;
		bk_q2        = 16'h5ac2;
		is_gbc_game1 = 1'b0;
		is_gbc_game2 = 1'b0;
		lfsr_state   = 32'h695e_07c1;
		pal_model    = `GB_PALETTE_DEFAULT;
		cases_run    = 0;

		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		// Idle state after reset
		check("req.rd", req.rd, 1'b0);
		check("req.wr", req.wr, 1'b0);
		check("bk_busy", bk_busy, 1'b0);
		check("bk_loading", bk_loading, 1'b0);
		check("led_busy", led_busy, 1'b0);
		check("dl_start", dl_start, 1'b0);
		check("dl_end", dl_end, 1'b0);
		check("palette", palette, pal_model[`GB_PALETTE_W-1:32]);
		check("tint_loaded", tint_loaded, 1'b0);

		run_cases();

		if (cases_run == 0) begin
			$display("ERROR: no scenarios were found in the cases file");
			abort_run();
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

// File: rtl/gb_support_top.sv
/*
 * Support logic around the two handheld cores.
 * All settings are levels from the host status word.
 * bk_wr1 and bk_wr2 share one address and data bus.
 */
`include "gb_support_macros.svh"

module gb_support_top (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  gb_support_pkg::dl_bus_t     dl,
	input  gb_support_pkg::user_opts_t  opts,
	input  logic                        osd_open,
	input  gb_support_pkg::sd_host_t    sd,
	input  logic                        cram_wr1,
	input  logic                        cram_wr2,
	input  logic                        has_save1,
	input  logic                        has_save2,
	input  logic [`GB_DL_DATA_W-1:0]    bk_q1,
	input  logic [`GB_DL_DATA_W-1:0]    bk_q2,
	input  logic                        is_gbc_game1,
	input  logic                        is_gbc_game2,
	output gb_support_pkg::dl_kind_t    kind,
	output logic                        dl_start,
	output logic                        dl_end,
	output logic                        rom_bank_gb2,
	output logic                        core_reset,
	output logic                        is_gbc,
	output logic                        megaduck,
	output gb_support_pkg::boot_caps_t  caps,
	output logic [`GB_CHECKSUM_W-1:0]   checksum,
	output gb_support_pkg::palette_t    palette,
	output logic                        tint_loaded,
	output gb_support_pkg::sd_req_t     req,
	output logic [`GB_DL_DATA_W-1:0]    sd_buff_din,
	output logic [`GB_BK_ADDR_W-1:0]    bk_addr,
	output logic [`GB_DL_DATA_W-1:0]    bk_data,
	output logic                        bk_wr1,
	output logic                        bk_wr2,
	output logic                        bk_busy,
	output logic                        bk_loading,
	output logic                        sav_pending,
	output logic                        sav_supported,
	output logic                        led_busy
);

	////////////////////////////////////////////////////////////
	// Downloads and console mode
	////////////////////////////////////////////////////////////
	download_classifier i_classifier (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.opts         (opts),
		.bk_loading   (bk_loading),
		.is_gbc_game1 (is_gbc_game1),
		.is_gbc_game2 (is_gbc_game2),
		.kind         (kind),
		.dl_start     (dl_start),
		.dl_end       (dl_end),
		.rom_bank_gb2 (rom_bank_gb2),
		.core_reset   (core_reset),
		.is_gbc       (is_gbc),
		.megaduck     (megaduck)
	);

	boot_rom_monitor i_boot_mon (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.kind     (kind),
		.is_gbc   (is_gbc),
		.caps     (caps),
		.checksum (checksum)
	);

	palette_store i_palette (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.kind        (kind),
		.palette     (palette),
		.tint_loaded (tint_loaded)
	);

	////////////////////////////////////////////////////////////
	// Backup RAM
	////////////////////////////////////////////////////////////
	backup_ram_sequencer i_backup (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.opts           (opts),
		.osd_open       (osd_open),
		.dl_active_cart (kind.cart),
		.dl_start       (dl_start),
		.dl_end         (dl_end),
		.sd             (sd),
		.cram_wr1       (cram_wr1),
		.cram_wr2       (cram_wr2),
		.has_save1      (has_save1),
		.has_save2      (has_save2),
		.bk_q1          (bk_q1),
		.bk_q2          (bk_q2),
		.req            (req),
		.sd_buff_din    (sd_buff_din),
		.bk_addr        (bk_addr),
		.bk_data        (bk_data),
		.bk_wr1         (bk_wr1),
		.bk_wr2         (bk_wr2),
		.bk_busy        (bk_busy),
		.bk_loading     (bk_loading),
		.sav_pending    (sav_pending),
		.sav_supported  (sav_supported)
	);

	// User LED shows any download or an unsaved game
	assign led_busy = dl.active | sav_pending;

endmodule

// File: rtl/backup_ram_sequencer.sv
/*
 * Moves cart RAM of both cores to and from the SD image, one sector at a time.
 * Sectors 0..255 belong to core one and 256..511 to core two.
 * Duplicate mode transfers only the first half and feeds it to core two.
 * The host must drop ack to finish each sector.
 */
`include "gb_support_macros.svh"

module backup_ram_sequencer (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  gb_support_pkg::user_opts_t  opts,
	input  logic                        osd_open,
	input  logic                        dl_active_cart,
	input  logic                        dl_start,
	input  logic                        dl_end,
	input  gb_support_pkg::sd_host_t    sd,
	input  logic                        cram_wr1,
	input  logic                        cram_wr2,
	input  logic                        has_save1,
	input  logic                        has_save2,
	input  logic [`GB_DL_DATA_W-1:0]    bk_q1,
	input  logic [`GB_DL_DATA_W-1:0]    bk_q2,
	output gb_support_pkg::sd_req_t     req,
	output logic [`GB_DL_DATA_W-1:0]    sd_buff_din,
	output logic [`GB_BK_ADDR_W-1:0]    bk_addr,
	output logic [`GB_DL_DATA_W-1:0]    bk_data,
	output logic                        bk_wr1,
	output logic                        bk_wr2,
	output logic                        bk_busy,
	output logic                        bk_loading,
	output logic                        sav_pending,
	output logic                        sav_supported
);

	gb_support_pkg::sd_req_t req_q;

	logic bk_ena;
	logic ack_d;
	logic load_d;
	logic save_d;
	logic bk_load;
	logic bk_save;
	logic user_start;
	logic auto_load;
	logic last_sector;
	logic dupe;

	assign dupe          = opts.dupe_save_gb2;
	assign sav_supported = (has_save1 | has_save2) & bk_ena;

	// Image is mounted near the end of a cart download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			if (dl_start)
				bk_ena <= 1'b0;
			if (dl_active_cart && sd.img_mounted && !sd.img_readonly)
				bk_ena <= 1'b1;

			if ((cram_wr1 | cram_wr2) && !osd_open && sav_supported)
				sav_pending <= 1'b1;
			else if (bk_busy)
				sav_pending <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////////////////////////
	assign bk_load     = opts.load_req;
	assign bk_save     = opts.save_req | (sav_pending & osd_open & opts.autosave);
	assign user_start  = bk_ena & ((bk_load & ~load_d) | (bk_save & ~save_d));
	assign auto_load   = dl_end & sd.img_present & bk_ena;
	assign last_sector = req_q.lba[8:0] == `GB_SECTOR_LAST_FULL ||
	                     (dupe && req_q.lba[8:0] == `GB_SECTOR_LAST_DUPE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_q      <= '0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			ack_d      <= 1'b0;
			load_d     <= 1'b0;
			save_d     <= 1'b0;
		end else begin
			ack_d  <= sd.ack;
			load_d <= bk_load;
			save_d <= bk_save;

			// Host has taken the request
			if (sd.ack && !ack_d) begin
				req_q.rd <= 1'b0;
				req_q.wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (auto_load) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					req_q.lba  <= '0;
					req_q.rd   <= 1'b1;
					req_q.wr   <= 1'b0;
				end else if (user_start) begin
					bk_busy    <= 1'b1;
					bk_loading <= bk_load;
					req_q.lba  <= '0;
					req_q.rd   <= bk_load;
					req_q.wr   <= ~bk_load;
				end
			end else if (!sd.ack && ack_d) begin
				// Sector done
				if (last_sector) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					req_q.lba <= req_q.lba + 1'b1;
					req_q.rd  <= bk_loading;
					req_q.wr  <= ~bk_loading;
				end
			end
		end
	end

	assign req = req_q;

	////////////////////////////////////////////////////////////
	// Buffer routing
	////////////////////////////////////////////////////////////
	// Top address bit stays clear since each core sees 64K words
	assign bk_addr     = {1'b0, req_q.lba[7:0], sd.buff_addr};
	assign bk_data     = sd.buff_dout;
	assign bk_wr1      = ~req_q.lba[8] & ~(opts.rom_load_gb2 & dupe) & sd.buff_wr & sd.ack;
	assign bk_wr2      = (req_q.lba[8] | dupe) & sd.buff_wr & sd.ack;
	assign sd_buff_din = req_q.lba[8] ? bk_q2 : bk_q1;

endmodule

// File: rtl/palette_store.sv
/*
 * Custom palette register, loaded one 16-bit word per palette write.
 * Words arrive byte swapped and shift in from the bottom.
 * Only the upper 96 bits carry colours.
 */
`include "gb_support_macros.svh"

module palette_store (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  gb_support_pkg::dl_bus_t  dl,
	input  gb_support_pkg::dl_kind_t kind,
	output gb_support_pkg::palette_t palette,
	output logic                     tint_loaded
);

	logic [`GB_PALETTE_W-1:0] pal_sr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pal_sr      <= `GB_PALETTE_DEFAULT;
			tint_loaded <= 1'b0;
		end else if (kind.palette && dl.wr) begin
			pal_sr      <= {pal_sr[`GB_PALETTE_W-17:0], dl.data[7:0], dl.data[15:8]};
			tint_loaded <= 1'b1;
		end
	end

	// Lightest colour sits in the top bytes
	assign palette = pal_sr[`GB_PALETTE_W-1 -: $bits(gb_support_pkg::palette_t)];

endmodule

// File: rtl/boot_rom_monitor.sv
/*
 * Watches boot ROM downloads and sums the bytes of colour boot ROMs.
 * A word written in the first cycle of a download is not counted.
 * Custom ROM flags stay set until reset.
 */
`include "gb_support_macros.svh"

module boot_rom_monitor (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  gb_support_pkg::dl_bus_t          dl,
	input  gb_support_pkg::dl_kind_t         kind,
	input  logic                             is_gbc,
	output gb_support_pkg::boot_caps_t       caps,
	output logic [`GB_CHECKSUM_W-1:0]        checksum
);

	logic       boot_d;
	logic       custom_cgb;
	logic       custom_dmg;
	logic [8:0] byte_sum;
	logic       sum_is_mister;

	assign byte_sum = {1'b0, dl.data[15:8]} + {1'b0, dl.data[7:0]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boot_d     <= 1'b0;
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
			checksum   <= '0;
		end else begin
			boot_d <= kind.cgb_boot | kind.dmg_boot | kind.sgb_boot;
			if (kind.cgb_boot)
				custom_cgb <= 1'b1;
			if (kind.dmg_boot)
				custom_dmg <= 1'b1;

			// New colour boot download restarts the sum
			if (kind.cgb_boot && !boot_d)
				checksum <= '0;
			else if (kind.cgb_boot && dl.wr)
				checksum <= checksum + {{(`GB_CHECKSUM_W-9){1'b0}}, byte_sum};
		end
	end

	////////////////////////////////////////////////////////////
	// Capabilities
	////////////////////////////////////////////////////////////
	assign sum_is_mister      = checksum == `GB_CHECKSUM_MISTER_CGB0;
	assign caps.real_cgb_bios = checksum == `GB_CHECKSUM_ORIGINAL_CGB;

	// Own or original colour ROMs know how to enter GBA mode
	assign caps.gba_available = !custom_cgb || caps.real_cgb_bios || sum_is_mister;

	// Fast boot needs a ROM built for it
	assign caps.fastboot_available = !((is_gbc && custom_cgb && !sum_is_mister) ||
	                                   (!is_gbc && custom_dmg));

endmodule

// File: rtl/download_classifier.sv
/*
 * Decodes host downloads and holds the cores while carts or boot ROMs load.
 * Console mode and MegaDuck flags only change while core_reset is high.
 * Raw carts (slot zero) take their colour mode from the cores' header flags.
 */
`include "gb_support_macros.svh"

module download_classifier (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gb_support_pkg::dl_bus_t    dl,
	input  gb_support_pkg::user_opts_t opts,
	input  logic                       bk_loading,
	input  logic                       is_gbc_game1,
	input  logic                       is_gbc_game2,
	output gb_support_pkg::dl_kind_t   kind,
	output logic                       dl_start,
	output logic                       dl_end,
	output logic                       rom_bank_gb2,
	output logic                       core_reset,
	output logic                       is_gbc,
	output logic                       megaduck
);

	logic cart_d;
	logic boot_any;
	logic sys_auto;
	logic sys_md;

	always_comb begin
		kind          = '0;
		// Slot 1 covers 0x81 too, so a MegaDuck download is also a cart
		kind.cart     = dl.active && (dl.index.slot_view.slot == `GB_DL_CART_SLOT ||
		                dl.index.code == `GB_DL_CART_RAW);
		kind.megaduck = dl.active && dl.index.code == `GB_DL_MEGADUCK;
		kind.palette  = dl.active && dl.index.code == `GB_DL_PALETTE;
		kind.cgb_boot = dl.active && dl.index.code == `GB_DL_CGB_BOOT;
		kind.dmg_boot = dl.active && dl.index.code == `GB_DL_DMG_BOOT;
		kind.sgb_boot = dl.active && dl.index.code == `GB_DL_SGB_BOOT;
	end

	assign boot_any   = kind.cgb_boot | kind.dmg_boot | kind.sgb_boot;
	assign core_reset = reset | opts.manual_reset | kind.cart | boot_any | bk_loading;
	assign sys_auto   = opts.sys_mode == gb_support_pkg::SYS_AUTO;
	assign sys_md     = opts.sys_mode == gb_support_pkg::SYS_MEGADUCK;

	// Cart download edges
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_d       <= 1'b0;
			dl_start     <= 1'b0;
			dl_end       <= 1'b0;
			rom_bank_gb2 <= 1'b0;
		end else begin
			cart_d   <= kind.cart;
			dl_start <= kind.cart & ~cart_d;
			dl_end   <= ~kind.cart & cart_d;
			if (kind.cart & ~cart_d)
				rom_bank_gb2 <= opts.rom_load_gb2;
		end
	end

	////////////////////////////////////////////////////////////
	// Console mode latch
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			is_gbc   <= opts.sys_mode == gb_support_pkg::SYS_GBC;
			megaduck <= 1'b0;
		end else if (core_reset) begin
			// MegaDuck download overrides the plain cart rule
			if (kind.cart)
				megaduck <= sys_md;
			if (kind.megaduck)
				megaduck <= sys_auto | sys_md;

			if (!sys_auto)
				is_gbc <= opts.sys_mode == gb_support_pkg::SYS_GBC;
			else if (kind.cart) begin
				if (dl.index.slot_view.slot == 6'd0)
					is_gbc <= is_gbc_game1 | is_gbc_game2;
				else
					is_gbc <= dl.index.slot_view.cart_flags == 2'b00;
			end
		end
	end

endmodule

// File: rtl/gb_support_pkg.sv
/*
 * Types shared by the support blocks and the testbench.
 * The download index is read both as a raw code and as slot plus flags.
 * Colour values are 24-bit RGB with red in the top byte.
 */
`include "gb_support_macros.svh"

package gb_support_pkg;

	// Index as slot number with two console flags on top
	typedef struct packed {
		logic [1:0] cart_flags;
		logic [5:0] slot;
	} dl_slot_t;

	typedef union packed {
		logic [7:0] code;
		dl_slot_t   slot_view;
	} dl_index_u;

	typedef struct packed {
		logic                      active;
		logic                      wr;
		logic [`GB_DL_ADDR_W-1:0]  addr;
		logic [`GB_DL_DATA_W-1:0]  data;
		dl_index_u                 index;
	} dl_bus_t;

	// One flag per download kind, each already qualified by active
	typedef struct packed {
		logic cart;
		logic megaduck;
		logic palette;
		logic cgb_boot;
		logic dmg_boot;
		logic sgb_boot;
	} dl_kind_t;

	typedef enum logic [1:0] {
		SYS_AUTO     = 2'd0,
		SYS_GB       = 2'd1,
		SYS_GBC      = 2'd2,
		SYS_MEGADUCK = 2'd3
	} sys_mode_e;

	typedef struct packed {
		sys_mode_e sys_mode;
		logic      manual_reset;
		logic      rom_load_gb2;
		logic      dupe_save_gb2;
		logic      autosave;
		logic      load_req;
		logic      save_req;
	} user_opts_t;

	////////////////////////////////////////////////////////////
	// SD card side
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic        ack;
		logic        buff_wr;
		logic [7:0]  buff_addr;
		logic [15:0] buff_dout;
		logic        img_mounted;
		logic        img_readonly;
		logic        img_present;
	} sd_host_t;

	typedef struct packed {
		logic [`GB_SD_LBA_W-1:0] lba;
		logic                    rd;
		logic                    wr;
	} sd_req_t;

	typedef struct packed {
		logic fastboot_available;
		logic gba_available;
		logic real_cgb_bios;
	} boot_caps_t;

	typedef logic [`GB_COLOR_W-1:0] color_t;

	typedef struct packed {
		color_t lightest;
		color_t light;
		color_t dark;
		color_t darkest;
	} palette_t;

endpackage

// File: rtl/gb_support_macros.svh
/*
 * Shared widths and constants for the handheld support logic.
 * Boot ROM checksums are byte sums truncated to 18 bits.
 * Download codes are the host's file index values.
 * The default palette packs four 24-bit colours over 32 unused bits.
 */
`ifndef GB_SUPPORT_MACROS_SVH
`define GB_SUPPORT_MACROS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////
`define GB_DL_ADDR_W    25
`define GB_DL_DATA_W    16
`define GB_SD_LBA_W     32
`define GB_BK_ADDR_W    17
`define GB_COLOR_W      24
`define GB_PALETTE_W    128
`define GB_CHECKSUM_W   18

// Known colour boot ROMs
`define GB_CHECKSUM_MISTER_CGB0   18'h2CE10
`define GB_CHECKSUM_ORIGINAL_CGB  18'h2F3EA

// Lightest colour first, unused bytes last
`define GB_PALETTE_DEFAULT  128'h828214_517356_305A5F_1A3B49_00000000

// Last sector of a transfer
`define GB_SECTOR_LAST_FULL  9'h1FF
`define GB_SECTOR_LAST_DUPE  9'h0FF

////////////////////////////////////////////////////////////
// Download index codes
////////////////////////////////////////////////////////////
`define GB_DL_CART_SLOT  6'h01
`define GB_DL_PALETTE   8'h03
`define GB_DL_CGB_BOOT  8'h04
`define GB_DL_DMG_BOOT  8'h05
`define GB_DL_SGB_BOOT  8'h06
`define GB_DL_CART_RAW  8'h80
`define GB_DL_MEGADUCK  8'h81

`endif
